// File: Bender.yml
package:
  name: ctl_unit

sources:
  - ctl_pkg.sv
  - opcode_decoder.sv
  - ctl_sequencer.sv
  - micro_op_encoder.sv
  - ab_mode_encoder.sv
  - ctl_top.sv
  - target: simulation
    files:
      - ctl_sva.sv
      - ctl_tb.sv

// File: ab_mode_encoder.sv
// Address-bus operation encoder
`timescale 1ns/1ps
`default_nettype none

module ab_mode_encoder import ctl_pkg::*; (
    input  wire ctl_state_t state,
    input  wire logic       cond,
    input  wire byte_t      db,
    output ab_op_t          ab_op
);

    ab_mode_t   mode;
    logic [1:0] abl_sel;
    logic       abl_ci;
    logic       back;

    assign abl_sel = mode[1:0]; // Low address mux select
    assign abl_ci  = mode[2];   // Low address carry in
    assign back    = cond & db[7]; // Taken backward branch

    always_comb begin
        case (state)
            ST_SYNC, ST_IMM0, ST_ABS0: mode = MODE_NEXT;
            ST_ABS1: mode = MODE_ABS_IDX;
            ST_ZERO: mode = MODE_ZP_IDX;
            ST_DATA: mode = MODE_PC; // Return to instruction stream
            ST_COND: mode = MODE_BRANCH;
            default: mode = MODE_HOLD; // INIT and RDWR
        endcase
    end

    // Upper seven bits drive PC, AHL and ABH, low five drive ABL
    always_comb begin
        case (mode)
            MODE_HOLD:      ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            MODE_PC:        ab_op = {7'b000_1010, abl_sel, 2'b10, abl_ci};
            MODE_ABS_IDX:   ab_op = {7'b111_1110, abl_sel, 2'b01, abl_ci}; // {DB, AHL+idx}
            MODE_ZP_IDX:    ab_op = {7'b111_0000, abl_sel, 2'b01, abl_ci}; // {00, DB+idx}
            MODE_NEXT:      ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};
            MODE_BRANCH: begin
                if (back) begin
                    ab_op = {7'b011_0111, abl_sel, 2'b11, abl_ci}; // High byte minus one
                end else begin
                    ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};
                end
            end
            default:        ab_op = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: ctl_pkg.sv
// Control unit definitions
`default_nettype none

package ctl_pkg;

    // Control word layout, low to high
    localparam int CW_SRC_LSB  = 0;
    localparam int CW_SRC_W    = 4;
    localparam int CW_DST_LSB  = 4;
    localparam int CW_DST_W    = 2;
    localparam int CW_LD_BIT   = 6;   // Write result to register
    localparam int CW_ALU_LSB  = 7;
    localparam int CW_ALU_W    = 7;   // Shift, add and carry
    localparam int CW_ST_BIT   = 14;
    localparam int CW_RMW_BIT  = 15;
    localparam int CW_JMP_BIT  = 16;
    localparam int CW_ADDX_BIT = 17;
    localparam int CW_ADDY_BIT = 18;
    localparam int CW_FLAG_LSB = 19;
    localparam int CW_FLAG_W   = 10;
    localparam int CW_W        = 29;

    localparam int REG_OP_W  = 7;     // W, dst, src
    localparam int ALU_OP_W  = 9;     // ldm, bcd, shift, add, carry
    localparam int AB_MODE_W = 4;
    localparam int AB_OP_W   = 12;

    typedef logic [7:0]           byte_t;
    typedef logic [CW_W-1:0]      ctl_word_t;
    typedef logic [REG_OP_W-1:0]  reg_op_t;
    typedef logic [ALU_OP_W-1:0]  alu_op_t;
    typedef logic [CW_FLAG_W-1:0] flag_op_t;
    typedef logic [AB_MODE_W-1:0] ab_mode_t;
    typedef logic [AB_OP_W-1:0]   ab_op_t;

    // Register file codes
    localparam logic [CW_SRC_W-1:0] REG_X = 4'b0000;
    localparam logic [CW_SRC_W-1:0] REG_Y = 4'b0001;
    localparam logic [CW_SRC_W-1:0] REG_Z = 4'b0111;  // Reads as zero

    localparam alu_op_t ALU_LOAD_M  = 9'b10_00_000_00;
    localparam alu_op_t ALU_STORE_M = 9'b00_00_100_00;  // Pass register through

    // Address-bus modes
    localparam ab_mode_t MODE_HOLD      = 4'd0;
    localparam ab_mode_t MODE_PC        = 4'd1;
    localparam ab_mode_t MODE_ABS_IDX   = 4'd2;
    localparam ab_mode_t MODE_ZP_IDX    = 4'd3;
    localparam ab_mode_t MODE_NEXT      = 4'd4;
    localparam ab_mode_t MODE_BRANCH    = 4'd7;
    localparam ab_mode_t MODE_NEXT_KEEP = 4'd12;

    typedef enum logic [2:0] {
        ENTRY_IMPLIED,
        ENTRY_IMM,
        ENTRY_ZP,
        ENTRY_ABS,
        ENTRY_BRANCH
    } entry_t;

    typedef enum logic [3:0] {
        ST_INIT,
        ST_SYNC,
        ST_IMM0,
        ST_ZERO,
        ST_ABS0,
        ST_ABS1,
        ST_RDWR,
        ST_DATA,
        ST_COND
    } ctl_state_t;

endpackage

`default_nettype wire

// File: ctl_sequencer.sv
// Instruction state machine
`timescale 1ns/1ps
`default_nettype none

module ctl_sequencer import ctl_pkg::*; (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire entry_t    entry,
    input  wire ctl_word_t ctl_word,
    output ctl_state_t     state,
    output logic           sync
);

    ctl_state_t state_nxt;
    logic       rmw;
    logic       jmp;

    assign rmw  = ctl_word[CW_RMW_BIT];
    assign jmp  = ctl_word[CW_JMP_BIT];
    assign sync = (state == ST_SYNC); // Opcode fetch cycle

    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT: state_nxt = ST_SYNC;
            ST_SYNC: begin
                case (entry)
                    ENTRY_IMM:    state_nxt = ST_IMM0;
                    ENTRY_ZP:     state_nxt = ST_ZERO;
                    ENTRY_ABS:    state_nxt = ST_ABS0;
                    ENTRY_BRANCH: state_nxt = ST_COND;
                    default:      state_nxt = ST_SYNC; // Implied or unknown
                endcase
            end
            ST_ABS0: state_nxt = ST_ABS1;
            ST_ZERO: state_nxt = rmw ? ST_RDWR : ST_DATA;
            ST_ABS1: begin
                if (jmp) begin
                    state_nxt = ST_SYNC; // New PC already on the bus
                end else if (rmw) begin
                    state_nxt = ST_RDWR;
                end else begin
                    state_nxt = ST_DATA;
                end
            end
            ST_RDWR: state_nxt = ST_DATA;
            default: state_nxt = ST_SYNC; // IMM0, DATA, COND
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_INIT;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

// File: ctl_sva.sv
// Sync and write-enable assertions
`timescale 1ns/1ps
`default_nettype none

module ctl_sva (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic sync,
    input wire logic we
);

    property no_we_in_sync;
        @(posedge clk) disable iff (!arst_n) !(we && sync);
    endproperty

    // Write cycle is DATA, so the next cycle is a fetch
    property we_ends_instr;
        @(posedge clk) disable iff (!arst_n) we |=> (sync && !we);
    endproperty

    property we_low_in_reset;
        @(posedge clk) !arst_n |-> !we;
    endproperty

    no_we_in_sync_a: assert property (no_we_in_sync)
        else $error("Write enable high in an opcode fetch cycle");

    we_ends_instr_a: assert property (we_ends_instr)
        else $error("Write cycle not followed by an opcode fetch");

    we_low_in_reset_a: assert property (we_low_in_reset)
        else $error("Write enable high during reset");

endmodule

bind ctl_top ctl_sva sva_i (
    .clk    (clk),
    .arst_n (arst_n),
    .sync   (sync),
    .we     (we)
);

`default_nettype wire

// File: ctl_tb.sv
// Control unit testbench
`timescale 1ns/1ps
`default_nettype none

module ctl_tb import ctl_pkg::*; ();

    localparam int          NUM_INSTR      = 2000;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 5 + 100; // Longest instruction is 5
    localparam int          NUM_KEPT       = 77;
    localparam logic [31:0] SEED           = 32'h8fe24997;

    // Addressing classes of the model
    localparam logic [2:0] C_IMP = 3'd0;
    localparam logic [2:0] C_IMM = 3'd1;
    localparam logic [2:0] C_ZP  = 3'd2;
    localparam logic [2:0] C_ABS = 3'd3;
    localparam logic [2:0] C_BR  = 3'd4;

    // Flag update groups, N V - B D I Z C and carry source
    localparam logic [9:0] F_NZ   = 10'b1000011000;
    localparam logic [9:0] F_NZC  = 10'b1000011011;
    localparam logic [9:0] F_NVZC = 10'b1010011011;
    localparam logic [9:0] F_C    = 10'b0000000011;
    localparam logic [9:0] F_V    = 10'b0010000000;
    localparam logic [9:0] F_NV   = 10'b1100000000; // BIT immediate

    localparam logic [3:0] R_X   = 4'd0;
    localparam logic [3:0] R_Y   = 4'd1;
    localparam logic [3:0] R_A   = 4'd2;
    localparam logic [3:0] R_S   = 4'd3;
    localparam logic [3:0] R_INC = 4'd5; // Memory operand plus one
    localparam logic [3:0] R_DEC = 4'd6;
    localparam logic [3:0] R_Z   = 4'd7;
    localparam logic [1:0] D_X   = 2'd0;
    localparam logic [1:0] D_Y   = 2'd1;
    localparam logic [1:0] D_A   = 2'd2;
    localparam logic [1:0] D_S   = 2'd3;

    // Address-bus words, PC/AHL/ABH in the top seven bits
    localparam logic [11:0] AB_NEXT    = 12'h6C7; // AB+1
    localparam logic [11:0] AB_BR_FWD  = 12'h6DF;
    localparam logic [11:0] AB_BR_BACK = 12'h6FF; // High byte minus one

    logic     clk;
    logic     arst_n;
    byte_t    db;
    logic     cond;
    logic     sync;
    logic     we;
    flag_op_t flag_op;
    reg_op_t  reg_op;
    alu_op_t  alu_op;
    ab_op_t   ab_op;

    logic [31:0] rng;
    logic [16:0] prev_regs; // Flags, load, dst, src of the last instruction
    logic [6:0]  prev_alu;  // ALU field of the last instruction
    byte_t       kept_ops [NUM_KEPT];
    int          cycles = 0;

    ctl_top dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .db      (db),
        .cond    (cond),
        .sync    (sync),
        .we      (we),
        .flag_op (flag_op),
        .reg_op  (reg_op),
        .alu_op  (alu_op),
        .ab_op   (ab_op)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation stopped by cycle limit");
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] val);
        rng = lcg_step(rng);
        val = rng;
    endtask

    task automatic check_val(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, act, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    function automatic logic [2:0] op_class(input byte_t op);
        case (op)
            8'h09, 8'h29, 8'h49, 8'h69, 8'h89, 8'hA0, 8'hA2, 8'hA9, 8'hC0, 8'hC9,
            8'hE0, 8'hE9: return C_IMM;
            8'h05, 8'h25, 8'h45, 8'h65, 8'h85, 8'hA5, 8'hC5, 8'hE5, 8'h06, 8'h26,
            8'h46, 8'h66, 8'hC6, 8'hE6: return C_ZP;
            8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'h8D, 8'hAD, 8'hCD, 8'hED, 8'h0E, 8'h2E,
            8'h4E, 8'h6E, 8'hCE, 8'hEE, 8'hBD, 8'hB9, 8'h9D, 8'h99, 8'h7D, 8'hBE,
            8'hBC, 8'h4C: return C_ABS;
            8'h10, 8'h30, 8'h50, 8'h70, 8'h80, 8'h90, 8'hB0, 8'hD0, 8'hF0: return C_BR;
            default: return C_IMP; // Unknown opcodes run as NOP
        endcase
    endfunction

    function automatic logic is_store(input byte_t op);
        case (op)
            8'h85, 8'h8D, 8'h9D, 8'h99: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_rmw(input byte_t op);
        case (op)
            8'h06, 8'h26, 8'h46, 8'h66, 8'hC6, 8'hE6,
            8'h0E, 8'h2E, 8'h4E, 8'h6E, 8'hCE, 8'hEE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Register write and flag update seen at the next fetch
    function automatic logic [16:0] completion(input byte_t op);
        case (op)
            8'h1A, 8'h3A, 8'h09, 8'h29, 8'h49, 8'h05, 8'h25, 8'h45, 8'h0D, 8'h2D,
            8'h4D: return {F_NZ, 1'b1, D_A, R_A};
            8'h0A, 8'h2A, 8'h4A, 8'h6A: return {F_NZC, 1'b1, D_A, R_A};
            8'h69, 8'hE9, 8'h65, 8'hE5, 8'h6D, 8'hED, 8'h7D: return {F_NVZC, 1'b1, D_A, R_A};
            8'hA9, 8'hA5, 8'hAD, 8'hBD, 8'hB9: return {F_NZ, 1'b1, D_A, R_Z};
            8'hA2, 8'hBE: return {F_NZ, 1'b1, D_X, R_Z};
            8'hA0, 8'hBC: return {F_NZ, 1'b1, D_Y, R_Z};
            8'h88, 8'hC8: return {F_NZ, 1'b1, D_Y, R_Y};
            8'hCA, 8'hE8: return {F_NZ, 1'b1, D_X, R_X};
            8'h8A: return {F_NZ, 1'b1, D_A, R_X};
            8'h98: return {F_NZ, 1'b1, D_A, R_Y};
            8'h9A: return {10'b0, 1'b1, D_S, R_X};
            8'hA8: return {F_NZ, 1'b1, D_Y, R_A};
            8'hAA: return {F_NZ, 1'b1, D_X, R_A};
            8'hBA: return {F_NZ, 1'b1, D_X, R_S};
            8'h18, 8'h38: return {F_C, 1'b0, D_X, R_Z};
            8'hB8: return {F_V, 1'b0, D_X, R_Z};
            8'h89: return {F_NV, 1'b0, D_X, R_A};
            8'hC0: return {F_NZC, 1'b0, D_X, R_Y};
            8'hC9, 8'hC5, 8'hCD: return {F_NZC, 1'b0, D_X, R_A};
            8'hE0: return {F_NZC, 1'b0, D_X, R_X};
            8'h85, 8'h8D, 8'h9D, 8'h99: return {10'b0, 1'b0, D_X, R_A};
            8'h06, 8'h26, 8'h46, 8'h66, 8'h0E, 8'h2E, 8'h4E,
            8'h6E: return {F_NZC, 1'b0, D_X, R_Z};
            8'hC6, 8'hCE: return {F_NZ, 1'b0, D_X, R_DEC};
            8'hE6, 8'hEE: return {F_NZ, 1'b0, D_X, R_INC};
            default: return '0; // NOP, branches, JMP, unknown
        endcase
    endfunction

    // Shift, operation and carry-in of each opcode
    function automatic logic [6:0] alu_code(input byte_t op);
        case (op)
            8'h0A: return 7'b10_100_00;
            8'h2A: return 7'b10_100_10;
            8'h4A: return 7'b11_100_00;
            8'h6A: return 7'b11_100_10;
            8'h38: return 7'b00_101_01;
            8'h1A, 8'hC8, 8'hE8: return 7'b00_100_01;
            8'h3A, 8'h88, 8'hCA: return 7'b00_101_00;
            8'h8A, 8'h98, 8'h9A, 8'hA8, 8'hAA, 8'hBA, 8'h85, 8'h8D, 8'h9D,
            8'h99: return 7'b00_100_00;
            8'h29, 8'h25, 8'h2D, 8'h89: return 7'b00_001_00;
            8'h49, 8'h45, 8'h4D: return 7'b00_010_00;
            8'h69, 8'h65, 8'h6D, 8'h7D: return 7'b00_011_11;
            8'hC0, 8'hC9, 8'hC5, 8'hCD, 8'hE0: return 7'b00_110_01;
            8'hE9, 8'hE5, 8'hED: return 7'b00_110_11;
            8'h06, 8'h0E: return 7'b10_000_00;
            8'h26, 8'h2E: return 7'b10_000_10;
            8'h46, 8'h4E: return 7'b11_000_00;
            8'h66, 8'h6E: return 7'b11_000_10;
            8'hC6, 8'hCE, 8'hE6, 8'hEE: return 7'b00_011_00;
            default: return '0; // ORA, loads, flag clears, branches, JMP
        endcase
    endfunction

    function automatic int instr_len(input logic [2:0] cls, input logic rmw, input logic jmp);
        case (cls)
            C_IMM, C_BR: return 2;
            C_ZP:        return rmw ? 4 : 3;
            C_ABS:       return jmp ? 3 : (rmw ? 5 : 4);
            default:     return 1;
        endcase
    endfunction

    task automatic draw_opcode(output byte_t op);
        logic [31:0] r;
        next_rand(r);
        if (r[31:29] == 3'b000) begin
            op = r[15:8]; // Any byte, mostly unsupported
        end else begin
            op = kept_ops[r[23:8] % NUM_KEPT];
        end
    endtask

    task automatic sync_cycle(input byte_t op);
        logic [31:0] r;
        @(posedge clk);
        #1;
        next_rand(r);
        db   = op;
        cond = r[31];
        #2;
        check_val("sync", sync, 1);
        check_val("we", we, 0);
        check_val("ab_op", ab_op, AB_NEXT);
        check_val("reg_op", reg_op, prev_regs[6:0]);
        check_val("flag_op", flag_op, prev_regs[16:7]);
        check_val("alu_op", alu_op, {2'b10, prev_alu});
    endtask

    task automatic run_instr(input byte_t op);
        logic [2:0]  cls;
        logic        st;
        logic        rmw;
        logic        jmp;
        logic [6:0]  alu;
        int          len;
        logic [31:0] r;
        alu_op_t     exp_alu;
        cls = op_class(op);
        st  = is_store(op);
        rmw = is_rmw(op);
        jmp = (op == 8'h4C);
        alu = alu_code(op);
        len = instr_len(cls, rmw, jmp);
        sync_cycle(op);
        prev_regs = completion(op);
        prev_alu  = alu;
        for (int i = 1; i < len; i++) begin
            @(posedge clk);
            #1;
            next_rand(r);
            db   = r[23:16];
            cond = r[31];
            #2;
            check_val("sync", sync, 0);
            check_val("we", we, (st || rmw) && (i == len - 1)); // Write in DATA only
            if (cls == C_BR) begin
                check_val("ab_op", ab_op, (cond && db[7]) ? AB_BR_BACK : AB_BR_FWD);
            end
            if (cls == C_IMM || (rmw && i == len - 2)) begin
                exp_alu = ALU_LOAD_M; // IMM0 or RDWR
            end else if (i == len - 1 && (cls == C_ZP || (cls == C_ABS && !jmp))) begin
                if (st) begin
                    exp_alu = ALU_STORE_M;
                end else if (rmw) begin
                    exp_alu = {2'b00, alu};
                end else begin
                    exp_alu = {2'b10, alu};
                end
            end else begin
                exp_alu = '0;
            end
            check_val("alu_op", alu_op, exp_alu);
        end
    endtask

    initial begin
        byte_t op;
        arst_n    = 1'b0;
        db        = 8'h00;
        cond      = 1'b0;
        rng       = SEED;
        prev_regs = '0;
        prev_alu  = '0;
        kept_ops  = '{8'h0A, 8'h18, 8'h1A, 8'h2A, 8'h38, 8'h3A, 8'h4A, 8'h6A, 8'h88, 8'h8A,
                      8'h98, 8'h9A, 8'hA8, 8'hAA, 8'hB8, 8'hBA, 8'hC8, 8'hCA, 8'hE8, 8'hEA,
                      8'h09, 8'h29, 8'h49, 8'h69, 8'h89, 8'hA0, 8'hA2, 8'hA9, 8'hC0, 8'hC9,
                      8'hE0, 8'hE9, 8'h10, 8'h30, 8'h50, 8'h70, 8'h80, 8'h90, 8'hB0, 8'hD0,
                      8'hF0, 8'h4C, 8'h05, 8'h25, 8'h45, 8'h65, 8'h85, 8'hA5, 8'hC5, 8'hE5,
                      8'h06, 8'h26, 8'h46, 8'h66, 8'hC6, 8'hE6, 8'h0D, 8'h2D, 8'h4D, 8'h6D,
                      8'h8D, 8'hAD, 8'hCD, 8'hED, 8'h0E, 8'h2E, 8'h4E, 8'h6E, 8'hCE, 8'hEE,
                      8'hBD, 8'hB9, 8'h9D, 8'h99, 8'h7D, 8'hBE, 8'hBC};

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            if (i == 9) begin
                arst_n = 1'b1; // Release lands in the INIT cycle
            end
            #2;
            check_val("sync", sync, 0);
            check_val("we", we, 0);
        end

        for (int n = 0; n < NUM_INSTR; n++) begin
            draw_opcode(op);
            run_instr(op);
        end
        sync_cycle(8'hEA); // Completion of the last instruction

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: ctl_top.sv
// Instruction control unit
`timescale 1ns/1ps
`default_nettype none

module ctl_top import ctl_pkg::*; (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire byte_t db,
    input  wire logic  cond,
    output logic       sync,
    output logic       we,
    output flag_op_t   flag_op,
    output reg_op_t    reg_op,
    output alu_op_t    alu_op,
    output ab_op_t     ab_op
);

    entry_t     entry;
    ctl_word_t  ctl_word;
    ctl_state_t state;

    assign flag_op = ctl_word[CW_FLAG_LSB +: CW_FLAG_W]; // Straight from the table

    opcode_decoder decoder_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .db       (db),
        .sync     (sync),
        .entry    (entry),
        .ctl_word (ctl_word)
    );

    ctl_sequencer sequencer_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .entry    (entry),
        .ctl_word (ctl_word),
        .state    (state),
        .sync     (sync)
    );

    micro_op_encoder micro_op_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .state    (state),
        .ctl_word (ctl_word),
        .reg_op   (reg_op),
        .alu_op   (alu_op),
        .we       (we)
    );

    ab_mode_encoder ab_mode_i (
        .state (state),
        .cond  (cond),
        .db    (db),
        .ab_op (ab_op)
    );

endmodule

`default_nettype wire

// File: micro_op_encoder.sv
// Register and ALU operation encoder
`timescale 1ns/1ps
`default_nettype none

module micro_op_encoder import ctl_pkg::*; (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire ctl_state_t state,
    input  wire ctl_word_t  ctl_word,
    output reg_op_t         reg_op,
    output alu_op_t         alu_op,
    output logic            we
);

    logic [CW_SRC_W-1:0] src;
    logic [CW_DST_W-1:0] dst;
    logic [CW_ALU_W-1:0] alu;
    logic                ld;
    logic                st;
    logic                rmw;
    logic                add_x;
    logic                add_y;
    logic [CW_SRC_W-1:0] idx_src;

    assign src   = ctl_word[CW_SRC_LSB +: CW_SRC_W];
    assign dst   = ctl_word[CW_DST_LSB +: CW_DST_W];
    assign alu   = ctl_word[CW_ALU_LSB +: CW_ALU_W];
    assign ld    = ctl_word[CW_LD_BIT];
    assign st    = ctl_word[CW_ST_BIT];
    assign rmw   = ctl_word[CW_RMW_BIT];
    assign add_x = ctl_word[CW_ADDX_BIT];
    assign add_y = ctl_word[CW_ADDY_BIT];

    // Index register added to the address
    assign idx_src = add_x ? REG_X : (add_y ? REG_Y : REG_Z);

    always_comb begin
        case (state)
            ST_SYNC:          reg_op = {ld, dst, src};         // Finish previous instruction
            ST_ZERO, ST_ABS1: reg_op = {1'b0, 2'b00, idx_src};
            ST_DATA:          reg_op = {1'b0, dst, src};       // Operand for store
            default:          reg_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            ST_IMM0, ST_RDWR: alu_op = ALU_LOAD_M;
            ST_SYNC:          alu_op = {2'b10, alu};
            ST_DATA: begin
                if (st) begin
                    alu_op = ALU_STORE_M;
                end else if (rmw) begin
                    alu_op = {2'b00, alu}; // Modify value read in RDWR
                end else begin
                    alu_op = {2'b10, alu};
                end
            end
            default:          alu_op = '0;
        endcase
    end

    // Write lands in the cycle after the address is set up
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we <= 1'b0;
        end else begin
            we <= (state == ST_RDWR) || (st && (state == ST_ZERO || state == ST_ABS1));
        end
    end

endmodule

`default_nettype wire

// File: opcode_decoder.sv
// Opcode decode table
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder import ctl_pkg::*; (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire byte_t db,
    input  wire logic  sync,
    output entry_t     entry,
    output ctl_word_t  ctl_word
);

    // Entry path on top of the control word
    logic [$bits(entry_t)+CW_W-1:0] row;

    //   flags      YX JMS <> ADD CI W DR SRC
    always_comb begin
        case (db)
            8'h0A: row = {ENTRY_IMPLIED, 29'b1000011011_00_000_10_100_00_1_10_0010}; // ASL A
            8'h18: row = {ENTRY_IMPLIED, 29'b0000000011_00_000_00_000_00_0_00_0111}; // CLC
            8'h1A: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_01_1_10_0010}; // INC A
            8'h2A: row = {ENTRY_IMPLIED, 29'b1000011011_00_000_10_100_10_1_10_0010}; // ROL A
            8'h38: row = {ENTRY_IMPLIED, 29'b0000000011_00_000_00_101_01_0_00_0111}; // SEC
            8'h3A: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_101_00_1_10_0010}; // DEC A
            8'h4A: row = {ENTRY_IMPLIED, 29'b1000011011_00_000_11_100_00_1_10_0010}; // LSR A
            8'h6A: row = {ENTRY_IMPLIED, 29'b1000011011_00_000_11_100_10_1_10_0010}; // ROR A
            8'h88: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_101_00_1_01_0001}; // DEY
            8'h8A: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_00_1_10_0000}; // TXA
            8'h98: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_00_1_10_0001}; // TYA
            8'h9A: row = {ENTRY_IMPLIED, 29'b0000000000_00_000_00_100_00_1_11_0000}; // TXS
            8'hA8: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_00_1_01_0010}; // TAY
            8'hAA: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_00_1_00_0010}; // TAX
            8'hB8: row = {ENTRY_IMPLIED, 29'b0010000000_00_000_00_000_00_0_00_0111}; // CLV
            8'hBA: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_00_1_00_0011}; // TSX
            8'hC8: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_01_1_01_0001}; // INY
            8'hCA: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_101_00_1_00_0000}; // DEX
            8'hE8: row = {ENTRY_IMPLIED, 29'b1000011000_00_000_00_100_01_1_00_0000}; // INX
            8'hEA: row = {ENTRY_IMPLIED, 29'b0000000000_00_000_00_000_00_0_00_0000}; // NOP
            8'h09: row = {ENTRY_IMM, 29'b1000011000_00_000_00_000_00_1_10_0010}; // ORA #
            8'h29: row = {ENTRY_IMM, 29'b1000011000_00_000_00_001_00_1_10_0010}; // AND #
            8'h49: row = {ENTRY_IMM, 29'b1000011000_00_000_00_010_00_1_10_0010}; // EOR #
            8'h69: row = {ENTRY_IMM, 29'b1010011011_00_000_00_011_11_1_10_0010}; // ADC #
            8'h89: row = {ENTRY_IMM, 29'b1100000000_00_000_00_001_00_0_00_0010}; // BIT #
            8'hA0: row = {ENTRY_IMM, 29'b1000011000_00_000_00_000_00_1_01_0111}; // LDY #
            8'hA2: row = {ENTRY_IMM, 29'b1000011000_00_000_00_000_00_1_00_0111}; // LDX #
            8'hA9: row = {ENTRY_IMM, 29'b1000011000_00_000_00_000_00_1_10_0111}; // LDA #
            8'hC0: row = {ENTRY_IMM, 29'b1000011011_00_000_00_110_01_0_00_0001}; // CPY #
            8'hC9: row = {ENTRY_IMM, 29'b1000011011_00_000_00_110_01_0_00_0010}; // CMP #
            8'hE0: row = {ENTRY_IMM, 29'b1000011011_00_000_00_110_01_0_00_0000}; // CPX #
            8'hE9: row = {ENTRY_IMM, 29'b1010011011_00_000_00_110_11_1_10_0010}; // SBC #
            8'h10: row = {ENTRY_BRANCH, 29'b0}; // BPL
            8'h30: row = {ENTRY_BRANCH, 29'b0}; // BMI
            8'h50: row = {ENTRY_BRANCH, 29'b0}; // BVC
            8'h70: row = {ENTRY_BRANCH, 29'b0}; // BVS
            8'h80: row = {ENTRY_BRANCH, 29'b0}; // BRA
            8'h90: row = {ENTRY_BRANCH, 29'b0}; // BCC
            8'hB0: row = {ENTRY_BRANCH, 29'b0}; // BCS
            8'hD0: row = {ENTRY_BRANCH, 29'b0}; // BNE
            8'hF0: row = {ENTRY_BRANCH, 29'b0}; // BEQ
            8'h4C: row = {ENTRY_ABS, 29'b0000000000_00_100_00_000_00_0_00_0000}; // JMP
            8'h05: row = {ENTRY_ZP, 29'b1000011000_00_000_00_000_00_1_10_0010}; // ORA zp
            8'h25: row = {ENTRY_ZP, 29'b1000011000_00_000_00_001_00_1_10_0010}; // AND zp
            8'h45: row = {ENTRY_ZP, 29'b1000011000_00_000_00_010_00_1_10_0010}; // EOR zp
            8'h65: row = {ENTRY_ZP, 29'b1010011011_00_000_00_011_11_1_10_0010}; // ADC zp
            8'h85: row = {ENTRY_ZP, 29'b0000000000_00_001_00_100_00_0_00_0010}; // STA zp
            8'hA5: row = {ENTRY_ZP, 29'b1000011000_00_000_00_000_00_1_10_0111}; // LDA zp
            8'hC5: row = {ENTRY_ZP, 29'b1000011011_00_000_00_110_01_0_00_0010}; // CMP zp
            8'hE5: row = {ENTRY_ZP, 29'b1010011011_00_000_00_110_11_1_10_0010}; // SBC zp
            8'h06: row = {ENTRY_ZP, 29'b1000011011_00_010_10_000_00_0_00_0111}; // ASL zp
            8'h26: row = {ENTRY_ZP, 29'b1000011011_00_010_10_000_10_0_00_0111}; // ROL zp
            8'h46: row = {ENTRY_ZP, 29'b1000011011_00_010_11_000_00_0_00_0111}; // LSR zp
            8'h66: row = {ENTRY_ZP, 29'b1000011011_00_010_11_000_10_0_00_0111}; // ROR zp
            8'hC6: row = {ENTRY_ZP, 29'b1000011000_00_010_00_011_00_0_00_0110}; // DEC zp
            8'hE6: row = {ENTRY_ZP, 29'b1000011000_00_010_00_011_00_0_00_0101}; // INC zp
            8'h0D: row = {ENTRY_ABS, 29'b1000011000_00_000_00_000_00_1_10_0010}; // ORA abs
            8'h2D: row = {ENTRY_ABS, 29'b1000011000_00_000_00_001_00_1_10_0010}; // AND abs
            8'h4D: row = {ENTRY_ABS, 29'b1000011000_00_000_00_010_00_1_10_0010}; // EOR abs
            8'h6D: row = {ENTRY_ABS, 29'b1010011011_00_000_00_011_11_1_10_0010}; // ADC abs
            8'h8D: row = {ENTRY_ABS, 29'b0000000000_00_001_00_100_00_0_00_0010}; // STA abs
            8'hAD: row = {ENTRY_ABS, 29'b1000011000_00_000_00_000_00_1_10_0111}; // LDA abs
            8'hCD: row = {ENTRY_ABS, 29'b1000011011_00_000_00_110_01_0_00_0010}; // CMP abs
            8'hED: row = {ENTRY_ABS, 29'b1010011011_00_000_00_110_11_1_10_0010}; // SBC abs
            8'h0E: row = {ENTRY_ABS, 29'b1000011011_00_010_10_000_00_0_00_0111}; // ASL abs
            8'h2E: row = {ENTRY_ABS, 29'b1000011011_00_010_10_000_10_0_00_0111}; // ROL abs
            8'h4E: row = {ENTRY_ABS, 29'b1000011011_00_010_11_000_00_0_00_0111}; // LSR abs
            8'h6E: row = {ENTRY_ABS, 29'b1000011011_00_010_11_000_10_0_00_0111}; // ROR abs
            8'hCE: row = {ENTRY_ABS, 29'b1000011000_00_010_00_011_00_0_00_0110}; // DEC abs
            8'hEE: row = {ENTRY_ABS, 29'b1000011000_00_010_00_011_00_0_00_0101}; // INC abs
            8'hBD: row = {ENTRY_ABS, 29'b1000011000_01_000_00_000_00_1_10_0111}; // LDA abs,X
            8'hB9: row = {ENTRY_ABS, 29'b1000011000_10_000_00_000_00_1_10_0111}; // LDA abs,Y
            8'h9D: row = {ENTRY_ABS, 29'b0000000000_01_001_00_100_00_0_00_0010}; // STA abs,X
            8'h99: row = {ENTRY_ABS, 29'b0000000000_10_001_00_100_00_0_00_0010}; // STA abs,Y
            8'h7D: row = {ENTRY_ABS, 29'b1010011011_01_000_00_011_11_1_10_0010}; // ADC abs,X
            8'hBE: row = {ENTRY_ABS, 29'b1000011000_10_000_00_000_00_1_00_0111}; // LDX abs,Y
            8'hBC: row = {ENTRY_ABS, 29'b1000011000_01_000_00_000_00_1_01_0111}; // LDY abs,X
            default: row = '0; // One-cycle NOP, no register write
        endcase
    end

    assign entry = entry_t'(row[CW_W +: $bits(entry_t)]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctl_word <= '0;
        end else if (sync) begin
            ctl_word <= row[CW_W-1:0]; // Held for the whole instruction
        end
    end

endmodule

`default_nettype wire

// File: project.f
ctl_pkg.sv
opcode_decoder.sv
ctl_sequencer.sv
micro_op_encoder.sv
ab_mode_encoder.sv
ctl_top.sv
ctl_sva.sv
ctl_tb.sv
